// ==== bench/fir_tb.sv ====
// fir_tb
// testbench for the 27-tap symmetric FIR filter: drives impulse, random,
// clock-enable gap, valid gap and mid-stream reset traffic and compares
// every output against a reference model of the filter
`timescale 1ns/1ns

module fir_tb;
	import fir_pkg::*;

	// ************************************************************
	// run lengths and timing
	// ************************************************************
	localparam int CLK_PERIOD     = 100;
	localparam int RESET_CYCLES   = 3;
	localparam int IMPULSE_LEN    = 40;
	localparam int STREAM_LEN     = 300;
	localparam int GAP_LEN        = 300;
	localparam int VALID_GAP_LEN  = 300;
	localparam int PRE_RESET_LEN  = 40;
	localparam int POST_RESET_LEN = 80;
	// enough idle edges to push the last sample out
	localparam int FLUSH_LEN      = LATENCY + 2;
	localparam int TOTAL_CYCLES   = 2 * RESET_CYCLES + IMPULSE_LEN + STREAM_LEN + GAP_LEN
		+ VALID_GAP_LEN + PRE_RESET_LEN + POST_RESET_LEN + 5 * FLUSH_LEN;
	localparam int WATCHDOG_NS    = 2 * TOTAL_CYCLES * CLK_PERIOD;

	logic    clk;
	logic    reset;
	logic    i_clk_ena;
	sample_t i_sample;
	sample_t o_sample;

	int      seed = 32'h86aa5710;
	string   test_name;

	// model state
	tap_vec_t hist;
	sample_t  exp_q[$];
	sample_t  due;
	logic     have_due;
	logic     due_fresh;
	int       captured_valid;
	int       dropped_valid;
	int       data_checks;

	fir_top dut_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_sample),
		.o_sample  (o_sample)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ************************************************************
	// reference model
	// ************************************************************
	// h[0] is the newest sample, all arithmetic wraps at DW bits
	function automatic data_t fir_reference(input tap_vec_t h);
		data_t acc;
		data_t a;
		data_t b;
		data_t presum;
		data_t prod;
		acc = '0;
		for (int k = 0; k < NUM_UNIQ; k++) begin
			a = h[k];
			if (k == NUM_UNIQ - 1) begin
				// centre tap stands alone
				presum = a;
			end else begin
				b = h[NUM_TAPS-1-k];
				presum = a + b;
			end
			prod = presum * COEFF[k];
			acc = acc + prod;
		end
		return acc;
	endfunction

	// history cleared, pipeline refilled with untagged entries
	task automatic clear_model();
		sample_t idle;
		idle = '0;
		foreach (exp_q[i]) begin
			if (exp_q[i].valid) begin
				dropped_valid++;
			end
		end
		if (have_due && due_fresh && due.valid) begin
			dropped_valid++;
		end
		hist = '0;
		exp_q.delete();
		repeat (LATENCY - 1) exp_q.push_back(idle);
		due = idle;
		have_due = 1'b1;
		due_fresh = 1'b0;
	endtask

	task automatic capture_sample(input sample_t s);
		sample_t e;
		hist = {hist[NUM_TAPS-2:0], s.data};
		e.valid = s.valid;
		e.data = fir_reference(hist);
		if (s.valid) begin
			captured_valid++;
		end
		exp_q.push_back(e);
		if (exp_q.size() >= LATENCY) begin
			due = exp_q.pop_front();
			due_fresh = 1'b1;
			have_due = 1'b1;
		end
	endtask

	// ************************************************************
	// compare tasks
	// ************************************************************
	task automatic check_valid(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error [%s] valid: expected %0b, actual %0b", name, exp, act);
			$display("Regression failed");
			$fatal(1, "output valid mismatch");
		end
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("** Error [%s] data: expected %0d (0x%05h), actual %0d (0x%05h)",
				name, exp, exp, act, act);
			$display("Regression failed");
			$fatal(1, "output data mismatch");
		end
	endtask

	// output seen at an edge belongs to the entry popped one edge earlier;
	// on a disabled edge the same entry is checked again
	always @(posedge clk) begin
		if (reset) begin
			clear_model();
		end else begin
			if (have_due) begin
				check_valid(test_name, due.valid, o_sample.valid);
				if (due.valid) begin
					check_data(test_name, due.data, o_sample.data);
					if (due_fresh) begin
						data_checks++;
					end
				end
				due_fresh = 1'b0;
			end
			if (i_clk_ena) begin
				capture_sample(i_sample);
			end
		end
	end

	// ************************************************************
	// stimulus helpers
	// ************************************************************
	task automatic drive_sample(input logic ena, input logic vld, input data_t data);
		@(negedge clk);
		i_clk_ena = ena;
		i_sample.valid = vld;
		i_sample.data = data;
	endtask

	task automatic hold_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic flush_pipeline();
		repeat (FLUSH_LEN) drive_sample(1'b1, 1'b0, '0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
		$display("Regression failed");
		$fatal(1, "timeout");
	end

	// ************************************************************
	// tests
	// ************************************************************
	initial begin
		logic ena;
		logic vld;
		clk = 1'b0;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_sample = '0;
		hist = '0;
		have_due = 1'b0;
		due_fresh = 1'b0;
		due = '0;
		captured_valid = 0;
		dropped_valid = 0;
		data_checks = 0;
		test_name = "initial reset";
		hold_reset();

		// single 1 among zeros walks the coefficient table out and back
		test_name = "impulse response";
		drive_sample(1'b1, 1'b1, 18'sd1);
		repeat (IMPULSE_LEN - 1) drive_sample(1'b1, 1'b1, '0);
		flush_pipeline();

		test_name = "random stream";
		for (int i = 0; i < STREAM_LEN; i++) begin
			drive_sample(1'b1, 1'b1, data_t'($random(seed)));
		end
		flush_pipeline();

		// roughly one edge in four disabled
		test_name = "clock-enable gaps";
		for (int i = 0; i < GAP_LEN; i++) begin
			ena = ($random(seed) & 3) != 0;
			drive_sample(ena, 1'b1, data_t'($random(seed)));
		end
		flush_pipeline();

		test_name = "valid gaps";
		for (int i = 0; i < VALID_GAP_LEN; i++) begin
			vld = ($random(seed) & 1) != 0;
			drive_sample(1'b1, vld, data_t'($random(seed)));
		end
		flush_pipeline();

		test_name = "reset mid-stream";
		for (int i = 0; i < PRE_RESET_LEN; i++) begin
			drive_sample(1'b1, 1'b1, data_t'($random(seed)));
		end
		hold_reset();
		check_valid(test_name, 1'b0, o_sample.valid);
		for (int i = 0; i < POST_RESET_LEN; i++) begin
			drive_sample(1'b1, 1'b1, data_t'($random(seed)));
		end
		flush_pipeline();

		// every tagged sample not lost to a reset must have been compared
		if (data_checks > 0 && data_checks == captured_valid - dropped_valid) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("compared %0d tagged outputs, but %0d were expected",
				data_checks, captured_valid - dropped_valid);
			$display("Regression failed");
			$fatal(1, "output count mismatch");
		end
	end

endmodule

// ==== rtl/fir_adder_tree.sv ====
// fir_adder_tree
// registered binary adder tree, reduces the 14 products to one sum
// over TREE_LEVELS levels; odd leftovers pass through a register
`timescale 1ns/1ns

module fir_adder_tree (
	input  logic               clk,
	input  logic               i_clk_ena,
	input  fir_pkg::prod_vec_t i_prods,
	output fir_pkg::data_t     o_sum
);
	import fir_pkg::*;

	// number of values present at a given level, level 0 is the input
	function automatic int level_count(int lvl);
		int n;
		n = NUM_UNIQ;
		for (int i = 0; i < lvl; i++) begin
			n = (n + 1) / 2;
		end
		return n;
	endfunction

	// node[0] is the product vector, node[l] the registers of level l
	data_t node [TREE_LEVELS+1][NUM_UNIQ];

	genvar l, j;

	generate
		for (j = 0; j < NUM_UNIQ; j++) begin : g_in
			assign node[0][j] = i_prods[j];
		end

		// ************************************************************
		// tree levels 14 -> 7 -> 4 -> 2 -> 1
		// ************************************************************
		for (l = 0; l < TREE_LEVELS; l++) begin : g_level
			localparam int N_IN  = level_count(l);
			localparam int N_OUT = level_count(l + 1);

			for (j = 0; j < N_OUT; j++) begin : g_node
				if (2 * j + 1 < N_IN) begin : g_add
					// neighbouring pair, wraps at DW bits
					always_ff @(posedge clk) begin
						if (i_clk_ena) begin
							node[l+1][j] <= node[l][2*j] + node[l][2*j+1];
						end
					end
				end else begin : g_pass
					// leftover keeps the same delay as the summed paths
					always_ff @(posedge clk) begin
						if (i_clk_ena) begin
							node[l+1][j] <= node[l][2*j];
						end
					end
				end
			end
		end
	endgenerate

	assign o_sum = node[TREE_LEVELS][0];

endmodule

// ==== rtl/fir_pkg.sv ====
// fir_pkg
// shared types and constants for the 27-tap symmetric FIR filter:
// sample and tap vector types, coefficient table and pipeline depth

package fir_pkg;

	// ************************************************************
	// widths and sizes
	// ************************************************************
	localparam int DW          = 18;
	localparam int NUM_TAPS    = 27;
	// symmetric filter, so only half the taps (rounded up) are unique
	localparam int NUM_UNIQ    = (NUM_TAPS + 1) / 2;
	// adder levels to reduce NUM_UNIQ products to one
	localparam int TREE_LEVELS = $clog2(NUM_UNIQ);
	// tap register + pre-add + multiply + adder tree
	localparam int LATENCY     = 1 + 1 + 1 + TREE_LEVELS;

	// ************************************************************
	// types
	// ************************************************************
	typedef logic signed [DW-1:0] data_t;

	typedef struct packed {
		logic  valid;
		data_t data;
	} sample_t;

	// element 0 holds the newest sample
	typedef data_t [NUM_TAPS-1:0] tap_vec_t;
	typedef data_t [NUM_UNIQ-1:0] prod_vec_t;

	// coefficient table, index 13 is the centre tap
	localparam data_t [0:NUM_UNIQ-1] COEFF = '{
		18'sd88,   18'sd0,    -18'sd97,  -18'sd197, -18'sd294,
		-18'sd380, -18'sd447, -18'sd490, -18'sd504, -18'sd481,
		-18'sd420, -18'sd319, -18'sd178, 18'sd0
	};

endpackage

// ==== rtl/fir_preadd_mult.sv ====
// fir_preadd_mult
// folds each symmetric tap pair with a pre-adder, then multiplies the
// pre-sums by the coefficient table; one register stage for each step
`timescale 1ns/1ns

module fir_preadd_mult (
	input  logic               clk,
	input  logic               i_clk_ena,
	input  fir_pkg::tap_vec_t  i_taps,
	output fir_pkg::prod_vec_t o_prods
);
	import fir_pkg::*;

	prod_vec_t presum_q;
	prod_vec_t prod_q;

	// ************************************************************
	// pre-add stage
	// ************************************************************
	// tap k pairs with tap 26-k, wrapping at DW bits
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ - 1; k++) begin
				presum_q[k] <= i_taps[k] + i_taps[NUM_TAPS-1-k];
			end
			// odd length, the centre tap has no partner
			presum_q[NUM_UNIQ-1] <= i_taps[NUM_UNIQ-1];
		end
	end

	// ************************************************************
	// multiply stage
	// ************************************************************
	// only the low DW bits of each product are kept
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				prod_q[k] <= presum_q[k] * COEFF[k];
			end
		end
	end

	assign o_prods = prod_q;

endmodule

// ==== rtl/fir_tap_line.sv ====
// fir_tap_line
// input side of the filter: shifts each enabled sample into a
// 27-deep delay line and registers its valid tag alongside tap 0
`timescale 1ns/1ns

module fir_tap_line (
	input  logic              clk,
	input  logic              reset,
	input  logic              i_clk_ena,
	input  fir_pkg::sample_t  i_sample,
	output fir_pkg::tap_vec_t o_taps,
	output logic              o_valid
);
	import fir_pkg::*;

	tap_vec_t taps_q;
	logic     valid_q;

	// newest sample enters at tap 0, oldest falls off the top
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			taps_q  <= '0;
			valid_q <= 1'b0;
		end else if (i_clk_ena) begin
			taps_q  <= {taps_q[NUM_TAPS-2:0], i_sample.data};
			valid_q <= i_sample.valid;
		end
	end

	assign o_taps  = taps_q;
	assign o_valid = valid_q;

	// ************************************************************
	// checks
	// ************************************************************
	// flagged data must be known when it is captured
	a_valid_data_known: assert property (
		@(posedge clk) disable iff (reset)
		(i_clk_ena && i_sample.valid) |-> !$isunknown(i_sample.data)
	) else $error("tap line captured unknown data with valid set");

endmodule

// ==== rtl/fir_top.sv ====
// fir_top
// 27-tap symmetric FIR filter with clock enable and valid tag:
// tap line, pre-add and multiply, adder tree, valid alignment
`timescale 1ns/1ns

module fir_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_clk_ena,
	input  fir_pkg::sample_t i_sample,
	output fir_pkg::sample_t o_sample
);
	import fir_pkg::*;

	tap_vec_t  taps;
	logic      tap_valid;
	prod_vec_t prods;
	data_t     sum;

	// ************************************************************
	// input side
	// ************************************************************
	fir_tap_line tap_line_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_sample),
		.o_taps    (taps),
		.o_valid   (tap_valid)
	);

	// ************************************************************
	// arithmetic
	// ************************************************************
	fir_preadd_mult preadd_mult_i (
		.clk       (clk),
		.i_clk_ena (i_clk_ena),
		.i_taps    (taps),
		.o_prods   (prods)
	);

	fir_adder_tree adder_tree_i (
		.clk       (clk),
		.i_clk_ena (i_clk_ena),
		.i_prods   (prods),
		.o_sum     (sum)
	);

	// ************************************************************
	// output side
	// ************************************************************
	fir_valid_align valid_align_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (tap_valid),
		.i_sum     (sum),
		.o_sample  (o_sample)
	);

endmodule

// ==== rtl/fir_valid_align.sv ====
// fir_valid_align
// output side: delays the valid tag until the matching sum leaves the
// adder tree and packs both into the output sample
`timescale 1ns/1ns

module fir_valid_align (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_clk_ena,
	input  logic             i_valid,
	input  fir_pkg::data_t   i_sum,
	output fir_pkg::sample_t o_sample
);
	import fir_pkg::*;

	// tap 0 is already one edge in, so the rest of the pipe is LATENCY-1
	localparam int DEPTH = LATENCY - 1;

	logic [DEPTH-1:0] valid_sr;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_sr <= '0;
		end else if (i_clk_ena) begin
			valid_sr <= {valid_sr[DEPTH-2:0], i_valid};
		end
	end

	assign o_sample.valid = valid_sr[DEPTH-1];
	assign o_sample.data  = i_sum;

	// no stale tag may come out once reset has been released
	a_valid_low_after_reset: assert property (
		@(posedge clk) $fell(reset) |-> !o_sample.valid
	) else $error("output valid set right after reset");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile the FIR testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module fir_tb -o fir_sim

out=$(./obj_dir/fir_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Regression passed"; then
	echo "simulation: PASS"
else
	echo "simulation: FAIL"
	exit 1
fi

// ==== sim.f ====
rtl/fir_pkg.sv
rtl/fir_tap_line.sv
rtl/fir_preadd_mult.sv
rtl/fir_adder_tree.sv
rtl/fir_valid_align.sv
rtl/fir_top.sv
bench/fir_tb.sv
